// ==== design/mrnw_pkg.sv ====
`default_nettype none

package mrnw_pkg;

  // data and address widths
  localparam int WIDTH   = 8;
  localparam int BITADDR = 4;

  // address split, row in the low bits and bank above it
  localparam int BITVROW = 2;
  localparam int BITVBNK = 2;
  localparam int NUMVBNK = 4;
  localparam int NUMVROW = 4;

  // physical bank field keeps one spare bank
  localparam int BITPBNK = 3;

  // forward bit, physical bank, row
  localparam int BITPADR = 6;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVROW-1:0] row_t;
  typedef logic [BITVBNK-1:0] bank_t;
  typedef logic [BITPADR-1:0] padr_t;

endpackage

`default_nettype wire

// ==== design/mrnw_storage.sv ====
`default_nettype none

module mrnw_storage #(
  parameter int NUM_RD_PORTS = 2
) (
  input  wire                     clk,

  // single write port
  input  wire                     write,
  input  wire mrnw_pkg::addr_t    wr_adr,
  input  wire mrnw_pkg::data_t    din,

  // read ports, combinational
  input  wire mrnw_pkg::addr_t    rd_adr [NUM_RD_PORTS],
  output mrnw_pkg::data_t         raw_dout [NUM_RD_PORTS]
);

  localparam int DEPTH = 1 << mrnw_pkg::BITADDR;

  // sixteen words, contents are don't care until written
  mrnw_pkg::data_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_adr] <= din;
    end
  end

  // reads see the array before a same-cycle write lands
  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_rd
    assign raw_dout[p] = mem[rd_adr[p]];
  end

  // a write with an unknown address would corrupt an unknown word
  a_wr_adr_known: assert property (
    @(posedge clk) write |-> !$isunknown(wr_adr)
  ) else $error("write with unknown wr_adr");

endmodule

`default_nettype wire

// ==== design/mrnw_err_tracker.sv ====
`default_nettype none

module mrnw_err_tracker #(
  parameter int NUM_RD_PORTS = 2,
  parameter int ERR_MODE     = 2
) (
  input  wire                     clk,
  input  wire                     rst_n,

  // writes clear the flags of their location
  input  wire                     write,
  input  wire mrnw_pkg::addr_t    wr_adr,

  // error injection
  input  wire                     inj_serr,
  input  wire                     inj_derr,
  input  wire mrnw_pkg::addr_t    inj_adr,

  // read requests
  input  wire [NUM_RD_PORTS-1:0]  read,
  input  wire mrnw_pkg::addr_t    rd_adr [NUM_RD_PORTS],

  // per port error status, combinational
  output logic [NUM_RD_PORTS-1:0] raw_serr,
  output logic [NUM_RD_PORTS-1:0] raw_derr,
  output mrnw_pkg::padr_t         raw_padr [NUM_RD_PORTS]
);

  localparam int CNT_W = $clog2(mrnw_pkg::NUMVBNK + 1);

  mrnw_pkg::bank_t wr_bnk;
  mrnw_pkg::row_t  wr_row;
  mrnw_pkg::bank_t inj_bnk;
  mrnw_pkg::row_t  inj_row;

  // single and double error flags per bank and row
  logic serr_flag [mrnw_pkg::NUMVBNK][mrnw_pkg::NUMVROW];
  logic derr_flag [mrnw_pkg::NUMVBNK][mrnw_pkg::NUMVROW];

  assign wr_bnk  = wr_adr[mrnw_pkg::BITADDR-1 -: mrnw_pkg::BITVBNK];
  assign wr_row  = wr_adr[mrnw_pkg::BITVROW-1:0];
  assign inj_bnk = inj_adr[mrnw_pkg::BITADDR-1 -: mrnw_pkg::BITVBNK];
  assign inj_row = inj_adr[mrnw_pkg::BITVROW-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int b = 0; b < mrnw_pkg::NUMVBNK; b++) begin
        for (int r = 0; r < mrnw_pkg::NUMVROW; r++) begin
          serr_flag[b][r] <= 1'b0;
          derr_flag[b][r] <= 1'b0;
        end
      end
    end else begin
      if (inj_serr) begin
        serr_flag[inj_bnk][inj_row] <= 1'b1;
      end
      if (inj_derr) begin
        derr_flag[inj_bnk][inj_row] <= 1'b1;
      end
      // placed last so a write beats an injection at the same spot
      if (write) begin
        serr_flag[wr_bnk][wr_row] <= 1'b0;
        derr_flag[wr_bnk][wr_row] <= 1'b0;
      end
    end
  end

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_scan
    mrnw_pkg::bank_t             rd_bnk;
    mrnw_pkg::row_t              rd_row;
    logic [CNT_W-1:0]            s_cnt;
    logic                        d_any;
    logic                        hit;
    logic [mrnw_pkg::BITPBNK-1:0] hit_bnk;

    assign rd_bnk = rd_adr[p][mrnw_pkg::BITADDR-1 -: mrnw_pkg::BITVBNK];
    assign rd_row = rd_adr[p][mrnw_pkg::BITVROW-1:0];

    // walk banks downward so the lowest flagged bank is kept
    always_comb begin
      s_cnt   = '0;
      d_any   = 1'b0;
      hit     = 1'b0;
      hit_bnk = '0;
      for (int b = mrnw_pkg::NUMVBNK - 1; b >= 0; b--) begin
        if (serr_flag[b][rd_row]) begin
          s_cnt = s_cnt + 1'b1;
        end
        if (derr_flag[b][rd_row]) begin
          d_any = 1'b1;
        end
        if (serr_flag[b][rd_row] || derr_flag[b][rd_row]) begin
          hit     = 1'b1;
          hit_bnk = b[mrnw_pkg::BITPBNK-1:0];
        end
      end
    end

    // parity counts flagged banks, ecc uses the double flags
    assign raw_serr[p] = read[p] && ((ERR_MODE == 1) ? (s_cnt == 1) : (s_cnt != 0));
    assign raw_derr[p] = read[p] && ((ERR_MODE == 1) ? (s_cnt > 1) : d_any);

    // forward bit is always zero
    assign raw_padr[p] = !read[p] ? '0 :
                         hit      ? {1'b0, hit_bnk, rd_row} :
                                    {1'b0, 1'b0, rd_bnk, rd_row};
  end

  a_err_mode: assert property (
    @(posedge clk) (ERR_MODE == 1) || (ERR_MODE == 2)
  ) else $error("ERR_MODE must be 1 or 2");

endmodule

`default_nettype wire

// ==== design/mrnw_rd_pipe.sv ====
`default_nettype none

module mrnw_rd_pipe #(
  parameter int NUM_RD_PORTS = 2,
  parameter int MEM_DELAY    = 2
) (
  input  wire                     clk,
  input  wire                     rst_n,

  // unregistered read results
  input  wire [NUM_RD_PORTS-1:0]  read,
  input  wire mrnw_pkg::data_t    raw_dout [NUM_RD_PORTS],
  input  wire [NUM_RD_PORTS-1:0]  raw_serr,
  input  wire [NUM_RD_PORTS-1:0]  raw_derr,
  input  wire mrnw_pkg::padr_t    raw_padr [NUM_RD_PORTS],

  // results after MEM_DELAY cycles
  output logic [NUM_RD_PORTS-1:0] rd_vld,
  output mrnw_pkg::data_t         rd_dout [NUM_RD_PORTS],
  output logic [NUM_RD_PORTS-1:0] rd_serr,
  output logic [NUM_RD_PORTS-1:0] rd_derr,
  output mrnw_pkg::padr_t         rd_padr [NUM_RD_PORTS],
  output logic                    ready
);

  logic            vld_q  [NUM_RD_PORTS][MEM_DELAY];
  mrnw_pkg::data_t dout_q [NUM_RD_PORTS][MEM_DELAY];
  logic            serr_q [NUM_RD_PORTS][MEM_DELAY];
  logic            derr_q [NUM_RD_PORTS][MEM_DELAY];
  mrnw_pkg::padr_t padr_q [NUM_RD_PORTS][MEM_DELAY];

  // valid chain
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      for (int s = 0; s < MEM_DELAY; s++) begin
        if (!rst_n) begin
          vld_q[p][s] <= 1'b0;
        end else if (s == 0) begin
          vld_q[p][s] <= read[p];
        end else begin
          vld_q[p][s] <= vld_q[p][s-1];
        end
      end
    end
  end

  // payload chain
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      dout_q[p][0] <= raw_dout[p];
      serr_q[p][0] <= raw_serr[p];
      derr_q[p][0] <= raw_derr[p];
      padr_q[p][0] <= raw_padr[p];
      for (int s = 1; s < MEM_DELAY; s++) begin
        dout_q[p][s] <= dout_q[p][s-1];
        serr_q[p][s] <= serr_q[p][s-1];
        derr_q[p][s] <= derr_q[p][s-1];
        padr_q[p][s] <= padr_q[p][s-1];
      end
    end
  end

  for (genvar p = 0; p < NUM_RD_PORTS; p++) begin : g_out
    assign rd_vld[p]  = vld_q[p][MEM_DELAY-1];
    assign rd_dout[p] = dout_q[p][MEM_DELAY-1];
    assign rd_serr[p] = serr_q[p][MEM_DELAY-1];
    assign rd_derr[p] = derr_q[p][MEM_DELAY-1];
    assign rd_padr[p] = padr_q[p][MEM_DELAY-1];
  end

  // high from the first edge out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= 1'b1;
    end
  end

  a_vld_needs_ready: assert property (
    @(posedge clk) !ready |-> (rd_vld == '0)
  ) else $error("rd_vld high while not ready");

endmodule

`default_nettype wire

// ==== design/mrnw_top.sv ====
`default_nettype none

module mrnw_top #(
  parameter int NUM_RD_PORTS = 2,
  parameter int MEM_DELAY    = 2,
  // 1 parity, 2 ecc
  parameter int ERR_MODE     = 2
) (
  input  wire                     clk,
  input  wire                     rst_n,

  input  wire                     write,
  input  wire mrnw_pkg::addr_t    wr_adr,
  input  wire mrnw_pkg::data_t    din,

  input  wire                     inj_serr,
  input  wire                     inj_derr,
  input  wire mrnw_pkg::addr_t    inj_adr,

  input  wire [NUM_RD_PORTS-1:0]  read,
  input  wire mrnw_pkg::addr_t    rd_adr [NUM_RD_PORTS],
  output logic [NUM_RD_PORTS-1:0] rd_vld,
  output mrnw_pkg::data_t         rd_dout [NUM_RD_PORTS],
  output logic [NUM_RD_PORTS-1:0] rd_serr,
  output logic [NUM_RD_PORTS-1:0] rd_derr,
  output mrnw_pkg::padr_t         rd_padr [NUM_RD_PORTS],

  output logic                    ready
);

  // same-cycle read results, before the delay line
  mrnw_pkg::data_t         raw_dout [NUM_RD_PORTS];
  logic [NUM_RD_PORTS-1:0] raw_serr;
  logic [NUM_RD_PORTS-1:0] raw_derr;
  mrnw_pkg::padr_t         raw_padr [NUM_RD_PORTS];

  mrnw_storage #(
    .NUM_RD_PORTS (NUM_RD_PORTS)
  ) storage_i (
    .clk      (clk),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .rd_adr   (rd_adr),
    .raw_dout (raw_dout)
  );

  mrnw_err_tracker #(
    .NUM_RD_PORTS (NUM_RD_PORTS),
    .ERR_MODE     (ERR_MODE)
  ) err_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .write    (write),
    .wr_adr   (wr_adr),
    .inj_serr (inj_serr),
    .inj_derr (inj_derr),
    .inj_adr  (inj_adr),
    .read     (read),
    .rd_adr   (rd_adr),
    .raw_serr (raw_serr),
    .raw_derr (raw_derr),
    .raw_padr (raw_padr)
  );

  mrnw_rd_pipe #(
    .NUM_RD_PORTS (NUM_RD_PORTS),
    .MEM_DELAY    (MEM_DELAY)
  ) pipe_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .read     (read),
    .raw_dout (raw_dout),
    .raw_serr (raw_serr),
    .raw_derr (raw_derr),
    .raw_padr (raw_padr),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rd_serr  (rd_serr),
    .rd_derr  (rd_derr),
    .rd_padr  (rd_padr),
    .ready    (ready)
  );

endmodule

`default_nettype wire

// ==== dv/mrnw_tb_util.svh ====
`ifndef MRNW_TB_UTIL_SVH
`define MRNW_TB_UTIL_SVH
`default_nettype none

  // galois lfsr, stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = (lfsr >> 1) ^ ({32{lsb}} & LFSR_POLY);
      val  = {val[30:0], lsb};
    end
    return val;
  endfunction

  // expected read result from the shadow state
  function automatic void exp_read(input mrnw_pkg::addr_t adr, output mrnw_pkg::data_t dout,
                                   output logic serr, output logic derr,
                                   output mrnw_pkg::padr_t padr);
    mrnw_pkg::bank_t bnk;
    mrnw_pkg::row_t  row;
    int              cnt;
    logic            dbl;
    logic            found;
    bnk   = adr[3:2];
    row   = adr[1:0];
    cnt   = 0;
    dbl   = 1'b0;
    found = 1'b0;
    padr  = {1'b0, 1'b0, bnk, row};
    for (int b = 0; b < mrnw_pkg::NUMVBNK; b++) begin
      if (sh_serr[b][row]) begin
        cnt++;
      end
      if (sh_derr[b][row]) begin
        dbl = 1'b1;
      end
      // lowest flagged bank names the physical address
      if (!found && (sh_serr[b][row] || sh_derr[b][row])) begin
        found = 1'b1;
        padr  = {1'b0, 3'(b), row};
      end
    end
    dout = sh_mem[adr];
    if (ERR_MODE == 1) begin
      serr = (cnt == 1);
      derr = (cnt > 1);
    end else begin
      serr = (cnt > 0);
      derr = dbl;
    end
  endfunction

  task automatic compare_data(input string name, input mrnw_pkg::data_t got,
                              input mrnw_pkg::data_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic compare_padr(input string name, input mrnw_pkg::padr_t got,
                              input mrnw_pkg::padr_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // serr and derr
  task automatic compare_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // valid and ready
  task automatic compare_ctrl(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      stop_on_failure();
    end
  endtask

`default_nettype wire
`endif

// ==== dv/mrnw_tb.sv ====
`default_nettype none

module mrnw_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_RD    = 2;
  localparam int MEM_DELAY = 2;
  localparam int ERR_MODE  = 2;
  localparam logic [31:0] LFSR_POLY = 32'hD000_0001;

  logic                   clk;
  logic                   rst_n;
  logic                   write;
  mrnw_pkg::addr_t        wr_adr;
  mrnw_pkg::data_t        din;
  logic                   inj_serr;
  logic                   inj_derr;
  mrnw_pkg::addr_t        inj_adr;
  logic [NUM_RD-1:0]      read;
  mrnw_pkg::addr_t        rd_adr [NUM_RD];
  logic [NUM_RD-1:0]      rd_vld;
  mrnw_pkg::data_t        rd_dout [NUM_RD];
  logic [NUM_RD-1:0]      rd_serr;
  logic [NUM_RD-1:0]      rd_derr;
  mrnw_pkg::padr_t        rd_padr [NUM_RD];
  logic                   ready;

  // shadow copy of the memory and error flags
  mrnw_pkg::data_t sh_mem [1 << mrnw_pkg::BITADDR];
  logic sh_serr [mrnw_pkg::NUMVBNK][mrnw_pkg::NUMVROW];
  logic sh_derr [mrnw_pkg::NUMVBNK][mrnw_pkg::NUMVROW];

  // expected results per port, with the edge they are due at
  int              due_q  [NUM_RD][$];
  mrnw_pkg::data_t dout_q [NUM_RD][$];
  logic            serr_q [NUM_RD][$];
  logic            derr_q [NUM_RD][$];
  mrnw_pkg::padr_t padr_q [NUM_RD][$];

  int          edge_cnt = 0;
  logic        checking = 1'b0;
  logic [31:0] lfsr     = 32'd82600;

  mrnw_top #(
    .NUM_RD_PORTS (NUM_RD),
    .MEM_DELAY    (MEM_DELAY),
    .ERR_MODE     (ERR_MODE)
  ) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .inj_serr (inj_serr),
    .inj_derr (inj_derr),
    .inj_adr  (inj_adr),
    .read     (read),
    .rd_adr   (rd_adr),
    .rd_vld   (rd_vld),
    .rd_dout  (rd_dout),
    .rd_serr  (rd_serr),
    .rd_derr  (rd_derr),
    .rd_padr  (rd_padr),
    .ready    (ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at first failure");
  endtask

  // records expectations for this cycle's reads, then updates the shadow
  task automatic step();
    mrnw_pkg::data_t d;
    logic            s;
    logic            e;
    mrnw_pkg::padr_t pa;
    for (int p = 0; p < NUM_RD; p++) begin
      if (read[p]) begin
        exp_read(rd_adr[p], d, s, e, pa);
        due_q[p].push_back(edge_cnt + MEM_DELAY);
        dout_q[p].push_back(d);
        serr_q[p].push_back(s);
        derr_q[p].push_back(e);
        padr_q[p].push_back(pa);
      end
    end
    if (inj_serr) begin
      sh_serr[inj_adr[3:2]][inj_adr[1:0]] = 1'b1;
    end
    if (inj_derr) begin
      sh_derr[inj_adr[3:2]][inj_adr[1:0]] = 1'b1;
    end
    // write after injection, so it wins
    if (write) begin
      sh_mem[wr_adr] = din;
      sh_serr[wr_adr[3:2]][wr_adr[1:0]] = 1'b0;
      sh_derr[wr_adr[3:2]][wr_adr[1:0]] = 1'b0;
    end
    @(negedge clk);
    write    = 1'b0;
    inj_serr = 1'b0;
    inj_derr = 1'b0;
    read     = '0;
  endtask

  // every bank of one row, both ports, in opposite bank order
  task automatic read_row(input mrnw_pkg::row_t row);
    for (int b = 0; b < mrnw_pkg::NUMVBNK; b++) begin
      read      = 2'b11;
      rd_adr[0] = {2'(b), row};
      rd_adr[1] = {2'(3 - b), row};
      step();
    end
  endtask

  // compares every cycle once reset is over
  always @(posedge clk) begin
    if (checking) begin
      for (int p = 0; p < NUM_RD; p++) begin
        if (due_q[p].size() != 0 && due_q[p][0] == edge_cnt) begin
          compare_ctrl($sformatf("rd_vld[%0d]", p), rd_vld[p], 1'b1);
          compare_data($sformatf("rd_dout[%0d]", p), rd_dout[p], dout_q[p].pop_front());
          compare_err($sformatf("rd_serr[%0d]", p), rd_serr[p], serr_q[p].pop_front());
          compare_err($sformatf("rd_derr[%0d]", p), rd_derr[p], derr_q[p].pop_front());
          compare_padr($sformatf("rd_padr[%0d]", p), rd_padr[p], padr_q[p].pop_front());
          void'(due_q[p].pop_front());
        end else begin
          compare_ctrl($sformatf("rd_vld[%0d]", p), rd_vld[p], 1'b0);
        end
      end
    end
    edge_cnt++;
  end

  initial begin
    int wait_cnt;
    rst_n     = 1'b0;
    write     = 1'b0;
    wr_adr    = '0;
    din       = '0;
    inj_serr  = 1'b0;
    inj_derr  = 1'b0;
    inj_adr   = '0;
    // reads requested all through reset, valids must still stay low
    read      = '1;
    rd_adr[0] = '0;
    rd_adr[1] = '0;
    for (int b = 0; b < mrnw_pkg::NUMVBNK; b++) begin
      for (int r = 0; r < mrnw_pkg::NUMVROW; r++) begin
        sh_serr[b][r] = 1'b0;
        sh_derr[b][r] = 1'b0;
      end
    end

    repeat (16) begin
      @(negedge clk);
      compare_ctrl("ready", ready, 1'b0);
      compare_ctrl("rd_vld", |rd_vld, 1'b0);
    end
    rst_n    = 1'b1;
    read     = '0;
    checking = 1'b1;
    @(negedge clk);
    compare_ctrl("ready", ready, 1'b1);

    // fill every word, then read it all back on both ports
    for (int a = 0; a < 16; a++) begin
      write  = 1'b1;
      wr_adr = 4'(a);
      din    = 8'(take_bits(8));
      step();
    end
    for (int a = 0; a < 16; a++) begin
      read      = 2'b11;
      rd_adr[0] = 4'(a);
      rd_adr[1] = 4'(15 - a);
      step();
    end

    // single error in bank 2 of row 1
    inj_serr = 1'b1;
    inj_adr  = 4'h9;
    step();
    read_row(2'd1);

    // double error at bank 3 row 2, singles in banks 0 and 1 of row 3
    inj_derr = 1'b1;
    inj_adr  = 4'hE;
    step();
    inj_serr = 1'b1;
    inj_adr  = 4'h3;
    step();
    inj_serr = 1'b1;
    inj_adr  = 4'h7;
    step();
    read_row(2'd2);
    read_row(2'd3);

    // rewriting the flagged words clears them
    foreach (sh_mem[a]) begin
      if (sh_serr[a[3:2]][a[1:0]] || sh_derr[a[3:2]][a[1:0]]) begin
        write  = 1'b1;
        wr_adr = 4'(a);
        din    = 8'(take_bits(8));
        step();
      end
    end
    read_row(2'd1);
    read_row(2'd2);
    read_row(2'd3);

    // random traffic, injections kept rarer than writes
    for (int i = 0; i < 300; i++) begin
      write     = 1'(take_bits(1));
      wr_adr    = 4'(take_bits(4));
      din       = 8'(take_bits(8));
      inj_serr  = (take_bits(2) == 32'd3);
      inj_derr  = (take_bits(3) == 32'd7);
      inj_adr   = 4'(take_bits(4));
      read      = 2'(take_bits(2));
      rd_adr[0] = 4'(take_bits(4));
      rd_adr[1] = 4'(take_bits(4));
      step();
    end

    wait_cnt = 0;
    while (due_q[0].size() != 0 || due_q[1].size() != 0) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > 4 * MEM_DELAY + 8) begin
        $display("timeout: outstanding reads never returned a valid");
        stop_on_failure();
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

`include "mrnw_tb_util.svh"

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+dv
design/mrnw_pkg.sv
design/mrnw_storage.sv
design/mrnw_err_tracker.sv
design/mrnw_rd_pipe.sv
design/mrnw_top.sv
dv/mrnw_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mrnw_tb -Mdir obj_dir -f src.f

out=$(./obj_dir/Vmrnw_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "RESULT: PASS"; then
  exit 0
else
  exit 1
fi
